// File: Bender.yml
package:
  name: front_end

sources:
  # Design sources, package first
  - rtl/fetch_pkg.sv
  - rtl/pc_fetch_unit.sv
  - rtl/fetch_buffer.sv
  - rtl/instr_aligner.sv
  - rtl/front_end.sv

  # Testbench sources
  - target: test
    files:
      - test/front_end_checker.sv
      - test/tb_front_end.sv

// File: filelist.f
rtl/fetch_pkg.sv
rtl/pc_fetch_unit.sv
rtl/fetch_buffer.sv
rtl/instr_aligner.sv
rtl/front_end.sv
test/front_end_checker.sv
test/tb_front_end.sv

// File: rtl/fetch_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_buffer #(
    parameter int unsigned DEPTH = fetch_pkg::FETCH_BUFFER_DEPTH
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  push_i,
    input  fetch_pkg::data_word_t push_word_i,
    input  fetch_pkg::data_word_t push_addr_i,
    input  logic                  pop_i,
    output fetch_pkg::data_word_t head_word_o,
    output fetch_pkg::data_word_t head_addr_o,
    output logic                  empty_o,
    output logic                  full_o
);

    // ====================
    // Storage
    // ====================

    fetch_pkg::data_word_t word_mem [DEPTH];
    fetch_pkg::data_word_t addr_mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(DEPTH):0]   count_q;
    logic                     do_push;
    logic                     do_pop;

    // Count has one extra bit so a full buffer is told apart from an empty one
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == DEPTH[$clog2(DEPTH):0]);

    // Strobes are qualified so a bad request can never corrupt the pointers
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Head is read straight out of the array
    assign head_word_o = word_mem[rd_ptr_q];
    assign head_addr_o = addr_mem[rd_ptr_q];

    // ====================
    // Pointers and count
    // ====================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // A flush wins over a push or pop on the same edge
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap on their own because the depth is a power of two
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end

            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end

            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Array write, the entry becomes the head one cycle later at the earliest
    always_ff @(posedge clk_i) begin
        if (do_push && !flush_i) begin
            word_mem[wr_ptr_q] <= push_word_i;
            addr_mem[wr_ptr_q] <= push_addr_i;
        end
    end

endmodule : fetch_buffer

`default_nettype wire

// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // ====================
    // Widths
    // ====================

    // Width of a memory word, an address and a full instruction
    localparam int unsigned XLEN = 32;

    // One memory word, also used for addresses and assembled instructions
    typedef logic [XLEN-1:0] data_word_t;

    // One 16 bit parcel, the unit of the compressed instruction set
    typedef logic [15:0] half_word_t;

    // ====================
    // Fetch configuration
    // ====================

    // Entries in the buffer between fetch and realignment, kept a power of two
    localparam int unsigned FETCH_BUFFER_DEPTH = 4;

    // First address fetched once reset is released
    localparam data_word_t RESET_PC = 32'h0000_0000;

    // ====================
    // State encodings
    // ====================

    // Phases of the four phase request/acknowledge handshake on the memory side
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_RELEASE
    } fetch_state_t;

    // Where the next instruction starts relative to the word at the buffer head
    typedef enum logic [1:0] {
        ALIGN_LOWER,
        ALIGN_UPPER,
        ALIGN_CROSS
    } align_state_t;

endpackage : fetch_pkg

`default_nettype wire

// File: rtl/front_end.sv
`timescale 1ns/100ps
`default_nettype none

module front_end (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Instruction memory
    output logic                  mem_req_o,
    output fetch_pkg::data_word_t mem_addr_o,
    input  logic                  mem_ack_i,
    input  fetch_pkg::data_word_t mem_rdata_i,

    // Back end
    input  logic                  redirect_i,
    input  fetch_pkg::data_word_t redirect_pc_i,
    input  logic                  stall_i,
    output logic                  instr_valid_o,
    output fetch_pkg::data_word_t instr_o,
    output fetch_pkg::data_word_t instr_pc_o,
    output logic                  instr_compressed_o
);

    // ====================
    // Internal nets
    // ====================

    // Producer to buffer
    logic                  push;
    fetch_pkg::data_word_t push_word;
    fetch_pkg::data_word_t push_addr;
    logic                  buf_full;

    // Buffer to consumer
    logic                  buf_empty;
    logic                  pop;
    fetch_pkg::data_word_t head_word;
    fetch_pkg::data_word_t head_addr;

    // ====================
    // Fetch stages
    // ====================

    // Program counter and memory handshake
    pc_fetch_unit u_pc_fetch (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .redirect_i    ( redirect_i    ),
        .redirect_pc_i ( redirect_pc_i ),
        .buf_full_i    ( buf_full      ),
        .mem_ack_i     ( mem_ack_i     ),
        .mem_rdata_i   ( mem_rdata_i   ),
        .mem_req_o     ( mem_req_o     ),
        .mem_addr_o    ( mem_addr_o    ),
        .push_o        ( push          ),
        .push_word_o   ( push_word     ),
        .push_addr_o   ( push_addr     )
    );

    // Fetched words wait here, the redirect throws them all away
    fetch_buffer #(
        .DEPTH ( fetch_pkg::FETCH_BUFFER_DEPTH )
    ) u_fetch_buffer (
        .clk_i       ( clk_i      ),
        .rst_n_i     ( rst_n_i    ),
        .flush_i     ( redirect_i ),
        .push_i      ( push       ),
        .push_word_i ( push_word  ),
        .push_addr_i ( push_addr  ),
        .pop_i       ( pop        ),
        .head_word_o ( head_word  ),
        .head_addr_o ( head_addr  ),
        .empty_o     ( buf_empty  ),
        .full_o      ( buf_full   )
    );

    // Splits words into instructions for the back end
    instr_aligner u_instr_aligner (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .redirect_i         ( redirect_i         ),
        .redirect_pc_i      ( redirect_pc_i      ),
        .stall_i            ( stall_i            ),
        .head_word_i        ( head_word          ),
        .head_addr_i        ( head_addr          ),
        .empty_i            ( buf_empty          ),
        .pop_o              ( pop                ),
        .instr_valid_o      ( instr_valid_o      ),
        .instr_o            ( instr_o            ),
        .instr_pc_o         ( instr_pc_o         ),
        .instr_compressed_o ( instr_compressed_o )
    );

endmodule : front_end

`default_nettype wire

// File: rtl/instr_aligner.sv
`timescale 1ns/100ps
`default_nettype none

module instr_aligner (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  redirect_i,
    input  fetch_pkg::data_word_t redirect_pc_i,
    input  logic                  stall_i,
    input  fetch_pkg::data_word_t head_word_i,
    input  fetch_pkg::data_word_t head_addr_i,
    input  logic                  empty_i,
    output logic                  pop_o,
    output logic                  instr_valid_o,
    output fetch_pkg::data_word_t instr_o,
    output fetch_pkg::data_word_t instr_pc_o,
    output logic                  instr_compressed_o
);

    // ====================
    // Parcel split
    // ====================

    fetch_pkg::align_state_t state_q;
    fetch_pkg::align_state_t state_d;
    fetch_pkg::half_word_t   saved_half_q;
    fetch_pkg::half_word_t   low_parcel;
    fetch_pkg::half_word_t   high_parcel;
    fetch_pkg::data_word_t   instr_d;
    fetch_pkg::data_word_t   pc_d;
    logic                    low_compressed;
    logic                    high_compressed;
    logic                    compressed_d;
    logic                    instr_ready;
    logic                    pop_d;
    logic                    save_en;

    assign low_parcel  = head_word_i[15:0];
    assign high_parcel = head_word_i[fetch_pkg::XLEN-1:16];

    // A 32 bit instruction has both low bits set, anything else is compressed
    assign low_compressed  = (low_parcel[1:0] != 2'b11);
    assign high_compressed = (high_parcel[1:0] != 2'b11);

    // ====================
    // Realignment
    // ====================

    always_comb begin
        state_d      = state_q;
        instr_d      = head_word_i;
        pc_d         = head_addr_i;
        compressed_d = 1'b0;
        instr_ready  = 1'b0;
        pop_d        = 1'b0;
        save_en      = 1'b0;

        if (!empty_i) begin
            case (state_q)
                fetch_pkg::ALIGN_LOWER: begin
                    if (low_compressed) begin
                        // Keep the word, its upper half is looked at next
                        instr_d      = {16'h0000, low_parcel};
                        compressed_d = 1'b1;
                        instr_ready  = 1'b1;
                        state_d      = fetch_pkg::ALIGN_UPPER;
                    end else begin
                        // Whole word is one aligned instruction
                        instr_ready = 1'b1;
                        pop_d       = 1'b1;
                    end
                end

                fetch_pkg::ALIGN_UPPER: begin
                    // Either way the word is used up after this
                    pop_d = 1'b1;
                    if (high_compressed) begin
                        instr_d      = {16'h0000, high_parcel};
                        pc_d         = head_addr_i + 32'd2;
                        compressed_d = 1'b1;
                        instr_ready  = 1'b1;
                        state_d      = fetch_pkg::ALIGN_LOWER;
                    end else begin
                        // Start of a 32 bit instruction, its rest is in the next word
                        save_en = 1'b1;
                        state_d = fetch_pkg::ALIGN_CROSS;
                    end
                end

                fetch_pkg::ALIGN_CROSS: begin
                    // New low half sits above the saved one
                    // The start address is the saved half, one parcel below this word
                    instr_d     = {low_parcel, saved_half_q};
                    pc_d        = head_addr_i - 32'd2;
                    instr_ready = 1'b1;
                    state_d     = fetch_pkg::ALIGN_UPPER;
                end

                default: begin
                    state_d = fetch_pkg::ALIGN_LOWER;
                end
            endcase
        end
    end

    // Head only leaves the buffer when the result can really move on
    assign pop_o = pop_d && !stall_i && !redirect_i;

    // ====================
    // Control state
    // ====================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= fetch_pkg::ALIGN_LOWER;
            saved_half_q  <= '0;
            instr_valid_o <= 1'b0;
        end else if (redirect_i) begin
            // New path may start in the middle of a word
            state_q       <= redirect_pc_i[1] ? fetch_pkg::ALIGN_UPPER
                                              : fetch_pkg::ALIGN_LOWER;
            saved_half_q  <= '0;
            instr_valid_o <= 1'b0;
        end else if (!stall_i) begin
            state_q       <= state_d;
            instr_valid_o <= instr_ready;
            if (save_en) begin
                saved_half_q <= high_parcel;
            end
        end
    end

    // ====================
    // Output register
    // ====================

    // Payload holds while stalled, and also while nothing new is ready
    always_ff @(posedge clk_i) begin
        if (!stall_i && instr_ready) begin
            instr_o            <= instr_d;
            instr_pc_o         <= pc_d;
            instr_compressed_o <= compressed_d;
        end
    end

endmodule : instr_aligner

`default_nettype wire

// File: rtl/pc_fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module pc_fetch_unit (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  redirect_i,
    input  fetch_pkg::data_word_t redirect_pc_i,
    input  logic                  buf_full_i,
    input  logic                  mem_ack_i,
    input  fetch_pkg::data_word_t mem_rdata_i,
    output logic                  mem_req_o,
    output fetch_pkg::data_word_t mem_addr_o,
    output logic                  push_o,
    output fetch_pkg::data_word_t push_word_o,
    output fetch_pkg::data_word_t push_addr_o
);

    // ====================
    // Address selection
    // ====================

    fetch_pkg::fetch_state_t state_q;
    fetch_pkg::data_word_t   fetch_addr_q;
    fetch_pkg::data_word_t   req_addr_q;
    fetch_pkg::data_word_t   redirect_addr;
    fetch_pkg::data_word_t   next_addr;
    logic                    drop_q;
    logic                    ack_seen;
    logic                    keep_word;

    // Targets are halfword aligned, memory only serves whole words
    assign redirect_addr = {redirect_pc_i[fetch_pkg::XLEN-1:2], 2'b00};

    // A request opened on a redirect edge already goes to the new path
    assign next_addr = redirect_i ? redirect_addr : fetch_addr_q;

    // First cycle of an open request in which memory answers
    assign ack_seen = (state_q == fetch_pkg::FETCH_REQ) && mem_ack_i;

    // The word is thrown away if the path changed while it was in flight
    assign keep_word = !drop_q && !redirect_i;

    // Request is a plain decode of the handshake phase so it never glitches
    assign mem_req_o  = (state_q == fetch_pkg::FETCH_REQ);
    assign mem_addr_o = req_addr_q;

    // ====================
    // Handshake FSM
    // ====================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= fetch_pkg::FETCH_IDLE;
            fetch_addr_q <= fetch_pkg::RESET_PC;
            req_addr_q   <= fetch_pkg::RESET_PC;
            drop_q       <= 1'b0;
            push_o       <= 1'b0;
        end else begin
            // Push is a single cycle strobe
            push_o <= 1'b0;

            // The redirect target always becomes the next word to fetch
            if (redirect_i) begin
                fetch_addr_q <= redirect_addr;
            end

            case (state_q)
                fetch_pkg::FETCH_IDLE: begin
                    // Only start when the buffer can take the word and ack is low
                    if (!buf_full_i && !mem_ack_i) begin
                        state_q    <= fetch_pkg::FETCH_REQ;
                        req_addr_q <= next_addr;
                    end
                end

                fetch_pkg::FETCH_REQ: begin
                    if (mem_ack_i) begin
                        // Data is sampled now and the request falls on this edge
                        state_q <= fetch_pkg::FETCH_RELEASE;
                        push_o  <= keep_word;
                        drop_q  <= 1'b0;

                        // Step to the next word only on the path still in use
                        if (keep_word) begin
                            fetch_addr_q <= fetch_addr_q + 32'd4;
                        end
                    end else if (redirect_i) begin
                        // Transaction must finish but its word is stale
                        drop_q <= 1'b1;
                    end
                end

                fetch_pkg::FETCH_RELEASE: begin
                    // Wait for memory to let go of ack before a new request
                    if (!mem_ack_i) begin
                        state_q <= fetch_pkg::FETCH_IDLE;
                    end
                end

                default: begin
                    state_q <= fetch_pkg::FETCH_IDLE;
                end
            endcase
        end
    end

    // ====================
    // Push payload
    // ====================

    // Word and its address ride along with the push strobe
    always_ff @(posedge clk_i) begin
        if (ack_seen) begin
            push_word_o <= mem_rdata_i;
            push_addr_o <= req_addr_q;
        end
    end

endmodule : pc_fetch_unit

`default_nettype wire

// File: test/front_end_checker.sv
`timescale 1ns/100ps
`default_nettype none

module front_end_checker #(
    parameter int unsigned PROG_LEN = 400
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  mem_req_i,
    input  fetch_pkg::data_word_t mem_addr_i,
    input  logic                  mem_ack_i,
    input  logic                  redirect_i,
    input  fetch_pkg::data_word_t redirect_pc_i,
    input  logic                  stall_i,
    input  logic                  instr_valid_i,
    input  fetch_pkg::data_word_t instr_i,
    input  fetch_pkg::data_word_t instr_pc_i,
    input  logic                  instr_compressed_i,
    output logic                  done_o,
    output int unsigned           error_count_o
);

    // ====================
    // Reference program
    // ====================

    // Filled by the program generator before the first clock edge
    fetch_pkg::data_word_t exp_pc    [PROG_LEN];
    fetch_pkg::data_word_t exp_instr [PROG_LEN];
    logic                  exp_comp  [PROG_LEN];

    int unsigned           index_q;
    int unsigned           checked_q;
    logic                  prev_req_q;
    logic                  prev_ack_q;
    logic                  prev_hold_q;
    logic                  prev_valid_q;
    logic                  prev_comp_q;
    fetch_pkg::data_word_t prev_addr_q;
    fetch_pkg::data_word_t prev_instr_q;
    fetch_pkg::data_word_t prev_pc_q;

    task automatic record_instr(input int unsigned idx, input fetch_pkg::data_word_t pc,
                                input fetch_pkg::data_word_t value, input logic compressed);
        exp_pc[idx]    = pc;
        exp_instr[idx] = value;
        exp_comp[idx]  = compressed;
    endtask

    // Entry whose start address matches, PROG_LEN when there is none
    function automatic int unsigned find_index(input fetch_pkg::data_word_t pc);
        int unsigned found;
        found = PROG_LEN;
        for (int unsigned i = 0; i < PROG_LEN; i++) begin
            if (exp_pc[i] == pc) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic compare_value(input string name, input fetch_pkg::data_word_t expected,
                                 input fetch_pkg::data_word_t actual);
        if (expected !== actual) begin
            error_count_o = error_count_o + 1;
            $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_failure(input string what);
        error_count_o = error_count_o + 1;
        $display("failure: %s at %0t", what, $time);
    endtask

    task automatic print_summary();
        $display("checked %0d instructions, %0d errors", checked_q, error_count_o);
    endtask

    // ====================
    // Monitor
    // ====================

    // Sampled values here are the ones the DUT sees at the same edge
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            index_q       <= find_index(fetch_pkg::RESET_PC);
            checked_q     <= 0;
            done_o        <= 1'b0;
            error_count_o = 0;
            prev_req_q    <= 1'b0;
            prev_ack_q    <= 1'b0;
            prev_hold_q   <= 1'b0;
        end else if (!done_o) begin
            // Four phase handshake on the memory side
            if (mem_addr_i[1:0] != 2'b00) begin
                report_failure("mem_addr_o is not word aligned");
            end
            if (prev_req_q && !mem_req_i && !prev_ack_q) begin
                report_failure("mem_req_o fell before mem_ack_i was seen");
            end
            if (!prev_req_q && mem_req_i && mem_ack_i) begin
                report_failure("mem_req_o rose while mem_ack_i was still high");
            end
            if (prev_req_q && mem_req_i && (mem_addr_i != prev_addr_q)) begin
                report_failure("mem_addr_o changed during an open request");
            end

            // A stalled output must look exactly as it did one edge earlier
            if (prev_hold_q) begin
                compare_value("stall_hold.instr_valid_o", 32'(prev_valid_q), 32'(instr_valid_i));
                compare_value("stall_hold.instr_o", prev_instr_q, instr_i);
                compare_value("stall_hold.instr_pc_o", prev_pc_q, instr_pc_i);
                compare_value("stall_hold.instr_compressed_o", 32'(prev_comp_q),
                              32'(instr_compressed_i));
            end

            if (redirect_i) begin
                // The old path ends here, the target entry comes next
                index_q <= find_index(redirect_pc_i);
            end else if (instr_valid_i && !stall_i) begin
                if (index_q >= PROG_LEN) begin
                    report_failure("an instruction came out with no program entry left");
                end else begin
                    compare_value("sequence.instr_o", exp_instr[index_q], instr_i);
                    compare_value("sequence.instr_pc_o", exp_pc[index_q], instr_pc_i);
                    compare_value("sequence.instr_compressed_o", 32'(exp_comp[index_q]),
                                  32'(instr_compressed_i));
                    checked_q <= checked_q + 1;
                    if (index_q + 1 == PROG_LEN) begin
                        done_o <= 1'b1;
                    end
                end
                index_q <= index_q + 1;
            end

            prev_req_q   <= mem_req_i;
            prev_ack_q   <= mem_ack_i;
            prev_addr_q  <= mem_addr_i;
            prev_hold_q  <= instr_valid_i && stall_i && !redirect_i;
            prev_valid_q <= instr_valid_i;
            prev_instr_q <= instr_i;
            prev_pc_q    <= instr_pc_i;
            prev_comp_q  <= instr_compressed_i;
        end
    end

endmodule : front_end_checker

`default_nettype wire

// File: test/tb_front_end.sv
`timescale 1ns/100ps
`default_nettype none

module tb_front_end;

    // ====================
    // Test constants
    // ====================

    localparam int unsigned SEED              = 84;
    localparam int unsigned PROG_LEN          = 400;
    localparam int unsigned MEM_HALVES        = 1024;
    localparam int unsigned STALL_PCT         = 25;
    localparam int unsigned REDIRECT_PERMILLE = 8;
    localparam int unsigned MAX_REDIRECTS     = 6;
    localparam int unsigned MAX_MEM_DELAY     = 3;

    // Each redirect may replay the whole program at 12 cycles per instruction at worst
    localparam int unsigned CYCLE_LIMIT = PROG_LEN * 12 * (MAX_REDIRECTS + 1) + 1000;

    logic                  clk_i         = 1'b0;
    logic                  rst_n_i       = 1'b0;
    logic                  mem_ack_i     = 1'b0;
    fetch_pkg::data_word_t mem_rdata_i   = '0;
    logic                  redirect_i    = 1'b0;
    fetch_pkg::data_word_t redirect_pc_i = '0;
    logic                  stall_i       = 1'b0;
    logic                  mem_req_o;
    fetch_pkg::data_word_t mem_addr_o;
    logic                  instr_valid_o;
    fetch_pkg::data_word_t instr_o;
    fetch_pkg::data_word_t instr_pc_o;
    logic                  instr_compressed_o;
    logic                  done;
    int unsigned           error_count;
    int unsigned           cycle_count    = 0;
    int unsigned           redirect_count = 0;

    fetch_pkg::half_word_t mem_halves [MEM_HALVES];
    fetch_pkg::data_word_t prog_pc    [PROG_LEN];

    front_end dut0 (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .mem_req_o          ( mem_req_o          ),
        .mem_addr_o         ( mem_addr_o         ),
        .mem_ack_i          ( mem_ack_i          ),
        .mem_rdata_i        ( mem_rdata_i        ),
        .redirect_i         ( redirect_i         ),
        .redirect_pc_i      ( redirect_pc_i      ),
        .stall_i            ( stall_i            ),
        .instr_valid_o      ( instr_valid_o      ),
        .instr_o            ( instr_o            ),
        .instr_pc_o         ( instr_pc_o         ),
        .instr_compressed_o ( instr_compressed_o )
    );

    front_end_checker #(
        .PROG_LEN ( PROG_LEN )
    ) checker0 (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .mem_req_i          ( mem_req_o          ),
        .mem_addr_i         ( mem_addr_o         ),
        .mem_ack_i          ( mem_ack_i          ),
        .redirect_i         ( redirect_i         ),
        .redirect_pc_i      ( redirect_pc_i      ),
        .stall_i            ( stall_i            ),
        .instr_valid_i      ( instr_valid_o      ),
        .instr_i            ( instr_o            ),
        .instr_pc_i         ( instr_pc_o         ),
        .instr_compressed_i ( instr_compressed_o ),
        .done_o             ( done               ),
        .error_count_o      ( error_count        )
    );

    // ====================
    // Clock and reset
    // ====================

    initial begin
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    // ====================
    // Program and memory
    // ====================

    // Unused halfwords get a rotated copy of their index
    function automatic fetch_pkg::half_word_t fill_half(input int unsigned idx);
        return {idx[7:0], idx[15:8]} ^ 16'h5A5A;
    endfunction

    function automatic fetch_pkg::data_word_t read_word(input fetch_pkg::data_word_t addr);
        int unsigned idx;
        idx = addr >> 1;
        if (idx + 1 < MEM_HALVES) begin
            return {mem_halves[idx + 1], mem_halves[idx]};
        end else begin
            return ~addr;
        end
    endfunction

    initial begin : build_program
        int unsigned           seed_value;
        int unsigned           rnd;
        fetch_pkg::data_word_t pc;
        fetch_pkg::data_word_t value;
        logic                  compressed;
        seed_value = SEED;
        rnd        = $urandom(seed_value);
        for (int unsigned i = 0; i < MEM_HALVES; i++) begin
            mem_halves[i] = fill_half(i);
        end
        pc = fetch_pkg::RESET_PC;
        for (int unsigned i = 0; i < PROG_LEN; i++) begin
            rnd        = $urandom;
            compressed = rnd[31];
            value      = $urandom;
            if (compressed) begin
                // Low bits 00, 01 or 10 mark a compressed parcel
                value[31:16] = 16'h0000;
                if (value[1:0] == 2'b11) begin
                    value[1:0] = 2'b10;
                end
            end else begin
                value[1:0] = 2'b11;
            end
            mem_halves[pc >> 1] = value[15:0];
            if (!compressed) begin
                mem_halves[(pc >> 1) + 1] = value[31:16];
            end
            prog_pc[i] = pc;
            checker0.record_instr(i, pc, value, compressed);
            pc = pc + (compressed ? 32'd2 : 32'd4);
        end
    end

    // Answers one request at a time after a random delay
    initial begin : memory_model
        int unsigned delay;
        forever begin
            @(posedge clk_i);
            if (rst_n_i && mem_req_o && !mem_ack_i) begin
                delay = $urandom_range(MAX_MEM_DELAY, 0);
                repeat (delay) @(posedge clk_i);
                mem_ack_i   <= 1'b1;
                mem_rdata_i <= read_word(mem_addr_o);
                // Ack stays up until the request has fallen
                do begin
                    @(posedge clk_i);
                end while (mem_req_o);
                // Memory may take a few more cycles to let go of ack
                delay = $urandom_range(MAX_MEM_DELAY, 0);
                repeat (delay) @(posedge clk_i);
                mem_ack_i <= 1'b0;
            end
        end
    end

    // ====================
    // Back end stimulus
    // ====================

    always @(posedge clk_i) begin : drive_back_end
        int unsigned pick;
        if (!rst_n_i || done) begin
            stall_i    <= 1'b0;
            redirect_i <= 1'b0;
        end else begin
            stall_i <= ($urandom_range(99, 0) < STALL_PCT);
            // Redirects are single cycle pulses to a random instruction start
            if (!redirect_i && redirect_count < MAX_REDIRECTS
                && $urandom_range(999, 0) < REDIRECT_PERMILLE) begin
                pick           = $urandom_range(PROG_LEN - 1, 0);
                redirect_i     <= 1'b1;
                redirect_pc_i  <= prog_pc[pick];
                redirect_count <= redirect_count + 1;
            end else begin
                redirect_i <= 1'b0;
            end
        end
    end

    // ====================
    // End of run
    // ====================

    initial begin : run_control
        while (!done && cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_i);
        end
        if (!done) begin
            $display("timeout after %0d cycles, the end of the program was never reached",
                     cycle_count);
        end
        checker0.print_summary();
        if (done && error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : tb_front_end

`default_nettype wire
